// ==== source/elevator_pkg.sv ====
package elevator_pkg;

    //////////////////////////////
    // Building geometry
    //////////////////////////////

    // Eleven floors with floor 1 at index 0 and floor 11 at index 10
    localparam int NUM_FLOORS = 11;
    localparam int FLOOR_W    = $clog2(NUM_FLOORS);

    // Sweep direction reverses once per scan period
    localparam int SCAN_PERIOD = 11;
    localparam int SCAN_W      = $clog2(SCAN_PERIOD);

    //////////////////////////////
    // Floor types
    //////////////////////////////

    typedef logic [FLOOR_W-1:0]    floor_t;
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    //////////////////////////////
    // Port bundles
    //////////////////////////////

    // Raw button inputs from hall calls and car panel
    typedef struct packed {
        floor_mask_t call;
        floor_mask_t panel;
        logic        door_open;
        logic        door_close;
    } buttons_t;

    // Reported by the motion FSM
    typedef struct packed {
        floor_t current_floor;
        logic   moving;
    } car_status_t;

    // Command to the motion FSM
    typedef struct packed {
        floor_t target_floor;
        logic   sweep_up;
        logic   activate;
    } dispatch_t;

    // Door permissions
    typedef struct packed {
        logic open_allowed;
        logic close_allowed;
    } door_cmd_t;

    // Button illumination
    typedef struct packed {
        floor_mask_t call;
        floor_mask_t panel;
    } lights_t;

endpackage

// ==== source/request_latch.sv ====
`timescale 1ns/100ps

module request_latch
    import elevator_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  floor_mask_t buttons,
    input  logic        accept,
    input  floor_mask_t here_mask,
    input  logic        arrive,
    output floor_mask_t lights
);

    floor_mask_t set_mask;
    floor_mask_t clear_mask;
    floor_mask_t lights_next;

    //////////////////////////////
    // Set and clear terms
    //////////////////////////////

    // Every accepted press latches, except the one for the floor the car is at
    assign set_mask = accept ? (buttons & ~here_mask) : '0;

    // Stopped car at a floor drops that floor's request
    assign clear_mask = arrive ? here_mask : '0;

    assign lights_next = (lights | set_mask) & ~clear_mask;

    //////////////////////////////
    // Request lights
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else begin
            lights <= lights_next;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Floor where the car stood at the arrival edge is dark afterwards
    a_arrive_clears : assert property (
        @(posedge clk) disable iff (!reset_n)
        arrive |=> ((lights & $past(here_mask)) == '0)
    ) else $error("request light still lit one cycle after arrival");

endmodule

// ==== source/target_selector.sv ====
`timescale 1ns/100ps

module target_selector
    import elevator_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  floor_mask_t pending,
    input  logic        sweep_up,
    input  floor_t      current_floor,
    input  logic        reselect,
    output floor_t      target
);

    floor_t highest;
    floor_t lowest;
    floor_t next_target;
    logic   any_pending;

    //////////////////////////////
    // Priority searches
    //////////////////////////////

    // Upward scan where the last set bit seen wins
    always_comb begin
        highest = '0;
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (pending[i]) begin
                highest = floor_t'(i);
            end
        end
    end

    // Downward scan so the lowest set bit wins
    always_comb begin
        lowest = '0;
        for (int i = NUM_FLOORS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                lowest = floor_t'(i);
            end
        end
    end

    assign any_pending = |pending;

    //////////////////////////////
    // Target choice
    //////////////////////////////

    // Nothing to serve so stay where the car already is
    always_comb begin
        if (!any_pending) begin
            next_target = current_floor;
        end else if (sweep_up) begin
            next_target = highest;
        end else begin
            next_target = lowest;
        end
    end

    // Target is only re-evaluated once the car has reached the old one
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            target <= '0;
        end else if (reselect) begin
            target <= next_target;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Relies on the motion FSM reporting only valid floors
    a_target_range : assert property (
        @(posedge clk) disable iff (!reset_n)
        target < floor_t'(NUM_FLOORS)
    ) else $error("target floor %0d out of range", target);

endmodule

// ==== source/dispatch_control.sv ====
`timescale 1ns/100ps

module dispatch_control
    import elevator_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        power_switch,
    input  logic        emergency_btn,
    input  logic        door_open,
    input  logic        door_close,
    input  car_status_t car,
    input  floor_t      target,
    output logic        accept,
    output floor_mask_t here_mask,
    output logic        arrive,
    output logic        reselect,
    output dispatch_t   dispatch,
    output door_cmd_t   door
);

    logic [SCAN_W-1:0] scan_count;
    logic              scan_wrap;
    logic              sweep_up;
    logic              stopped;
    logic              at_target;
    logic              activate;

    //////////////////////////////
    // Scan timer and sweep
    //////////////////////////////

    // Timer runs 0 .. SCAN_PERIOD-1 and wraps
    assign scan_wrap = (scan_count == SCAN_W'(SCAN_PERIOD - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            scan_count <= '0;
        end else if (scan_wrap) begin
            scan_count <= '0;
        end else begin
            scan_count <= scan_count + 1'b1;
        end
    end

    // Direction flips on each wrap and starts going up
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sweep_up <= 1'b1;
        end else if (scan_wrap) begin
            sweep_up <= ~sweep_up;
        end
    end

    //////////////////////////////
    // Gating strobes
    //////////////////////////////

    assign stopped   = ~car.moving;
    assign at_target = (target == car.current_floor);

    // Requests only count with power on and no emergency
    assign accept = power_switch & ~emergency_btn;

    // One-hot of where the car is
    assign here_mask = floor_mask_t'(1) << car.current_floor;

    assign arrive   = stopped & power_switch;
    assign reselect = stopped & at_target;

    //////////////////////////////
    // Motion command
    //////////////////////////////

    // Send the car off whenever a new target differs from its position
    assign activate = accept & stopped & ~at_target;

    assign dispatch = '{
        target_floor: target,
        sweep_up:     sweep_up,
        activate:     activate
    };

    //////////////////////////////
    // Door permissions
    //////////////////////////////

    // Doors are locked out while moving or unpowered
    assign door.open_allowed  = door_open & stopped & power_switch;
    assign door.close_allowed = door_close & stopped & power_switch;

    //////////////////////////////
    // Checks
    //////////////////////////////

    a_no_activate_moving : assert property (
        @(posedge clk) disable iff (!reset_n)
        car.moving |-> !dispatch.activate
    ) else $error("activate raised while the car is moving");

endmodule

// ==== source/floor_logic_top.sv ====
`timescale 1ns/100ps

module floor_logic_top
    import elevator_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  buttons_t    buttons,
    input  logic        power_switch,
    input  logic        emergency_btn,
    input  car_status_t car,
    output dispatch_t   dispatch,
    output door_cmd_t   door,
    output lights_t     lights
);

    logic        accept;
    logic        arrive;
    logic        reselect;
    floor_mask_t here_mask;
    floor_mask_t call_lights;
    floor_mask_t panel_lights;
    floor_mask_t pending;
    floor_t      target;

    //////////////////////////////
    // Request lights
    //////////////////////////////

    // Hall call buttons
    request_latch call_latch (
        .clk       (clk),
        .reset_n   (reset_n),
        .buttons   (buttons.call),
        .accept    (accept),
        .here_mask (here_mask),
        .arrive    (arrive),
        .lights    (call_lights)
    );

    // Car panel buttons
    request_latch panel_latch (
        .clk       (clk),
        .reset_n   (reset_n),
        .buttons   (buttons.panel),
        .accept    (accept),
        .here_mask (here_mask),
        .arrive    (arrive),
        .lights    (panel_lights)
    );

    assign lights = '{call: call_lights, panel: panel_lights};

    // A floor is wanted if either light is on
    assign pending = call_lights | panel_lights;

    //////////////////////////////
    // Target and control
    //////////////////////////////

    target_selector selector (
        .clk           (clk),
        .reset_n       (reset_n),
        .pending       (pending),
        .sweep_up      (dispatch.sweep_up),
        .current_floor (car.current_floor),
        .reselect      (reselect),
        .target        (target)
    );

    dispatch_control control (
        .clk           (clk),
        .reset_n       (reset_n),
        .power_switch  (power_switch),
        .emergency_btn (emergency_btn),
        .door_open     (buttons.door_open),
        .door_close    (buttons.door_close),
        .car           (car),
        .target        (target),
        .accept        (accept),
        .here_mask     (here_mask),
        .arrive        (arrive),
        .reselect      (reselect),
        .dispatch      (dispatch),
        .door          (door)
    );

endmodule

// ==== verification/floor_logic_tb.sv ====
`timescale 1ns/100ps

module floor_logic_tb
    import elevator_pkg::*;
;

    localparam int RESET_CYCLES  = 10;
    localparam int RANDOM_ROUNDS = 24;

    // Reset per test, then the longest wait for a sweep phase plus the test body
    localparam int TEST_CYCLES = 6 * (RESET_CYCLES + 2) + 10 + 20
                               + (2 * SCAN_PERIOD + 20) + (5 * SCAN_PERIOD + 20)
                               + 20 + 4 * RANDOM_ROUNDS;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 200;

    logic        clk;
    logic        reset_n;
    buttons_t    buttons;
    logic        power_switch;
    logic        emergency_btn;
    car_status_t car;
    dispatch_t   dispatch;
    door_cmd_t   door;
    lights_t     lights;

    // Edges seen since reset release
    int          edges;
    logic [31:0] lfsr_state;

    floor_logic_top UUT (
        .clk           (clk),
        .reset_n       (reset_n),
        .buttons       (buttons),
        .power_switch  (power_switch),
        .emergency_btn (emergency_btn),
        .car           (car),
        .dispatch      (dispatch),
        .door          (door),
        .lights        (lights)
    );

    //////////////////////////////
    // Clock, edge count, watchdog
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            edges <= 0;
        end else begin
            edges <= edges + 1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Galois LFSR with one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic floor_mask_t floor_bit(input int f);
        floor_mask_t m;
        m = '0;
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (i == f) begin
                m[i] = 1'b1;
            end
        end
        return m;
    endfunction

    // Direction starts up and flips once every scan period
    function automatic logic expected_sweep(input int n);
        return ((n / SCAN_PERIOD) % 2) == 0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch on %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "check failed");
        end
    endtask

    task automatic apply_reset(input floor_t start_floor);
        @(posedge clk);
        reset_n       <= 1'b0;
        buttons       <= '0;
        power_switch  <= 1'b1;
        emergency_btn <= 1'b0;
        car           <= '{current_floor: start_floor, moving: 1'b0};
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
    endtask

    // Returns on the edge that samples the press
    task automatic press_buttons(input floor_mask_t call, input floor_mask_t panel);
        @(posedge clk);
        buttons.call  <= call;
        buttons.panel <= panel;
        @(posedge clk);
        buttons.call  <= '0;
        buttons.panel <= '0;
    endtask

    // Target loads two edges after the press starts, so look ahead by two
    task automatic wait_for_sweep(input logic dir);
        @(negedge clk);
        while (expected_sweep(edges + 2) != dir) begin
            check_value("dispatch.sweep_up", 32'(dispatch.sweep_up),
                        32'(expected_sweep(edges)));
            @(negedge clk);
        end
    endtask

    task automatic check_lights(input floor_mask_t call, input floor_mask_t panel);
        check_value("lights.call", 32'(lights.call), 32'(call));
        check_value("lights.panel", 32'(lights.panel), 32'(panel));
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_reset_state();
        apply_reset(4'd0);
        @(negedge clk);
        check_lights('0, '0);
        check_value("dispatch.activate", 32'(dispatch.activate), 32'd0);
        check_value("dispatch.target_floor", 32'(dispatch.target_floor), 32'd0);
        check_value("dispatch.sweep_up", 32'(dispatch.sweep_up), 32'd1);
        check_value("door.open_allowed", 32'(door.open_allowed), 32'd0);
        check_value("door.close_allowed", 32'(door.close_allowed), 32'd0);
    endtask

    task automatic test_latching_gating();
        floor_mask_t call;
        floor_mask_t panel;
        apply_reset(4'd0);
        // Power off
        @(posedge clk);
        power_switch <= 1'b0;
        press_buttons(floor_bit(1) | floor_bit(4), floor_bit(6));
        @(negedge clk);
        check_lights('0, '0);
        // Emergency on
        @(posedge clk);
        power_switch  <= 1'b1;
        emergency_btn <= 1'b1;
        press_buttons(floor_bit(2), floor_bit(8));
        @(negedge clk);
        check_lights('0, '0);
        // Car is at floor 1 already
        @(posedge clk);
        emergency_btn <= 1'b0;
        press_buttons(floor_bit(0), floor_bit(0));
        @(negedge clk);
        check_lights('0, '0);
        call  = floor_bit(0) | floor_bit(2) | floor_bit(9);
        panel = floor_bit(4) | floor_bit(9);
        press_buttons(call, panel);
        @(negedge clk);
        check_lights(call & ~floor_bit(0), panel);
        repeat (3) @(negedge clk);
        check_lights(call & ~floor_bit(0), panel);
    endtask

    task automatic test_upward_selection();
        apply_reset(4'd0);
        wait_for_sweep(1'b1);
        press_buttons(floor_bit(3) | floor_bit(7), floor_bit(5) | floor_bit(7));
        @(negedge clk);
        check_lights(floor_bit(3) | floor_bit(7), floor_bit(5) | floor_bit(7));
        @(negedge clk);
        check_value("dispatch.target_floor", 32'(dispatch.target_floor), 32'd7);
        check_value("dispatch.activate", 32'(dispatch.activate), 32'd1);
        // Motion FSM takes the car up
        @(posedge clk);
        car.moving <= 1'b1;
        @(negedge clk);
        check_value("dispatch.activate", 32'(dispatch.activate), 32'd0);
        @(posedge clk);
        car.current_floor <= 4'd7;
        @(posedge clk);
        car.moving <= 1'b0;
        @(negedge clk);
        check_lights(floor_bit(3) | floor_bit(7), floor_bit(5) | floor_bit(7));
        @(negedge clk);
        check_lights(floor_bit(3), floor_bit(5));
    endtask

    task automatic test_direction_reversal();
        apply_reset(4'd0);
        repeat (3 * SCAN_PERIOD) begin
            @(negedge clk);
            check_value("dispatch.sweep_up", 32'(dispatch.sweep_up),
                        32'(expected_sweep(edges)));
        end
        wait_for_sweep(1'b0);
        press_buttons(floor_bit(2) | floor_bit(8), floor_bit(9));
        @(negedge clk);
        check_lights(floor_bit(2) | floor_bit(8), floor_bit(9));
        @(negedge clk);
        check_value("dispatch.target_floor", 32'(dispatch.target_floor), 32'd2);
        check_value("dispatch.activate", 32'(dispatch.activate), 32'd1);
        check_value("dispatch.sweep_up", 32'(dispatch.sweep_up),
                    32'(expected_sweep(edges)));
    endtask

    task automatic check_doors(input logic open_ok, input logic close_ok);
        @(negedge clk);
        check_value("door.open_allowed", 32'(door.open_allowed), 32'(open_ok));
        check_value("door.close_allowed", 32'(door.close_allowed), 32'(close_ok));
    endtask

    task automatic test_door_permissions();
        apply_reset(4'd3);
        @(posedge clk);
        buttons.door_open <= 1'b1;
        check_doors(1'b1, 1'b0);
        @(posedge clk);
        buttons.door_open  <= 1'b0;
        buttons.door_close <= 1'b1;
        check_doors(1'b0, 1'b1);
        @(posedge clk);
        buttons.door_open <= 1'b1;
        car.moving        <= 1'b1;
        check_doors(1'b0, 1'b0);
        @(posedge clk);
        car.moving   <= 1'b0;
        power_switch <= 1'b0;
        check_doors(1'b0, 1'b0);
        @(posedge clk);
        power_switch <= 1'b1;
        check_doors(1'b1, 1'b1);
        @(posedge clk);
        buttons.door_open  <= 1'b0;
        buttons.door_close <= 1'b0;
    endtask

    task automatic test_random_presses();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] f;
        floor_mask_t call;
        floor_mask_t panel;
        floor_mask_t acc_call;
        floor_mask_t acc_panel;
        floor_t      floor_now;
        acc_call  = '0;
        acc_panel = '0;
        apply_reset(4'd4);
        // Held moving so nothing is ever cleared
        @(posedge clk);
        car.moving <= 1'b1;
        repeat (RANDOM_ROUNDS) begin
            // Two draws ANDed keep the masks sparse
            a = take_bits(NUM_FLOORS);
            b = take_bits(NUM_FLOORS);
            call = floor_mask_t'(a & b);
            a = take_bits(NUM_FLOORS);
            b = take_bits(NUM_FLOORS);
            panel = floor_mask_t'(a & b);
            f = take_bits(4);
            floor_now = floor_t'(f % NUM_FLOORS);
            @(posedge clk);
            car.current_floor <= floor_now;
            press_buttons(call, panel);
            acc_call  = acc_call | (call & ~floor_bit(int'(floor_now)));
            acc_panel = acc_panel | (panel & ~floor_bit(int'(floor_now)));
            @(negedge clk);
            check_lights(acc_call, acc_panel);
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        reset_n       = 1'b0;
        buttons       = '0;
        power_switch  = 1'b0;
        emergency_btn = 1'b0;
        car           = '0;
        lfsr_state    = 32'he6c6_2043;

        test_reset_state();
        test_latching_gating();
        test_upward_selection();
        test_direction_reversal();
        test_door_permissions();
        test_random_presses();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== tb.f ====
source/elevator_pkg.sv
source/request_latch.sv
source/target_selector.sv
source/dispatch_control.sv
source/floor_logic_top.sv
verification/floor_logic_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := floor_logic_tb
FILELIST   := tb.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Exit status of the simulation is the test result
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
